// ==== Makefile ====
TOP := fetch_unit_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f fetch_unit.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== fetch_unit.f ====
+incdir+include
source/fetch_pkg.sv
source/pc_gen.sv
source/l1i_cache.sv
source/predecode.sv
source/fetch_unit.sv
sim/imem_model.sv
sim/fetch_unit_tb.sv

// ==== include/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and data path width
`define FETCH_ADDR_W 32

// cache geometry, 8 lines of two words
`define L1I_LINES 8
`define L1I_IDX_W 3
`define L1I_OFS_W 3

// first fetch after reset
`define RESET_PC 32'h8000_0000

// special encodings seen by predecode
`define FENCE_I_INST 32'h0000_100f
`define OPC_JAL 7'b110_1111

`endif

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_GAP = 4;
  localparam int PROG_WORDS = 12;
  // straight code, the loop region twice, then one more refill
  localparam int RUN_FETCHES = 19;
  // two beats at the longest gap plus the pipeline around them
  localparam int FETCH_MAX_CYCLES = 2 * (MAX_GAP + 1) + 6;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + RUN_FETCHES * FETCH_MAX_CYCLES;
  localparam addr_t LOOP_PC = `RESET_PC + 32'h10;

  logic  clk;
  logic  rst;
  addr_t araddr;
  logic  arvalid;
  inst_t rdata;
  logic  rvalid;
  logic  fetch_valid;
  addr_t fetch_pc;
  inst_t fetch_inst;

  // program image and the expected successor of every word
  inst_t prog [16];
  addr_t succ [16];

  // expected contents of a direct-mapped cache of this geometry
  logic     line_valid [`L1I_LINES];
  l1i_tag_t line_tag [`L1I_LINES];
  logic     ever_filled [`L1I_LINES];

  addr_t exp_pc;
  logic  refill_seen;
  logic  prev_fetch_valid;
  int    fetch_count;
  int    loop_hits;
  int    refetches;

  fetch_unit dut_i (
    .clk           (clk),
    .rst           (rst),
    .araddr_o      (araddr),
    .arvalid_o     (arvalid),
    .rdata_i       (rdata),
    .rvalid_i      (rvalid),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc),
    .fetch_inst_o  (fetch_inst)
  );

  imem_model #(.MAX_GAP(MAX_GAP)) imem_i (
    .clk       (clk),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .rdata_o   (rdata),
    .rvalid_o  (rvalid)
  );

  function automatic l1i_idx_t index_of(input addr_t a);
    return a[`L1I_IDX_W+`L1I_OFS_W-1:`L1I_OFS_W];
  endfunction

  function automatic l1i_tag_t tag_of(input addr_t a);
    return a[`FETCH_ADDR_W-1:`L1I_IDX_W+`L1I_OFS_W];
  endfunction

  function automatic logic [3:0] slot_of(input addr_t a);
    addr_t ofs;
    ofs = a - `RESET_PC;
    return ofs[5:2];
  endfunction

  function automatic logic is_cached(input addr_t a);
    return line_valid[index_of(a)] && (line_tag[index_of(a)] == tag_of(a));
  endfunction

  // J-type layout imm[20|10:1|11|19:12]
  function automatic inst_t encode_jal(input logic [4:0] rd, input int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  function automatic inst_t encode_addi(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'b001_0011};
  endfunction

  task automatic put_word(input int k, input inst_t inst, input int step);
    prog[k] = inst;
    succ[k] = `RESET_PC + addr_t'(4 * k + step);
  endtask

  // the region from 0x10 is walked twice per round, even words then odd words
  task automatic load_program();
    put_word(0, encode_addi(5'd1, 12'd1), 4);
    put_word(1, encode_addi(5'd2, 12'd2), 4);
    put_word(2, encode_addi(5'd3, 12'd3), 4);
    put_word(3, encode_addi(5'd4, 12'd4), 4);
    put_word(4, encode_jal(5'd0, 8), 8);
    put_word(5, encode_jal(5'd0, 8), 8);
    put_word(6, encode_jal(5'd0, 8), 8);
    put_word(7, encode_jal(5'd0, 8), 8);
    put_word(8, encode_jal(5'd1, -12), -12);
    put_word(9, `FENCE_I_INST, 4);
    put_word(10, encode_jal(5'd0, -24), -24);
    put_word(11, encode_addi(5'd5, 12'd5), 4);
    for (int k = 0; k < PROG_WORDS; k++)
    begin
      imem_i.mem[k] = prog[k];
    end
  endtask

  task automatic stop_on_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
    $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic stop_with(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial
  begin
    rst = 1'b1;
    exp_pc = `RESET_PC;
    refill_seen = 1'b0;
    prev_fetch_valid = 1'b0;
    fetch_count = 0;
    loop_hits = 0;
    refetches = 0;
    for (int k = 0; k < `L1I_LINES; k++)
    begin
      line_valid[k] = 1'b0;
      line_tag[k] = '0;
      ever_filled[k] = 1'b0;
    end
    @(negedge clk);
    load_program();
    repeat (RESET_CYCLES - 1) @(negedge clk);
    rst = 1'b0;
    wait (fetch_count == RUN_FETCHES);
    if (loop_hits > 0 && refetches > 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      stop_with("loop hits or refills after FENCE.I were never reached");
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: only %0d of %0d fetches completed", fetch_count, RUN_FETCHES);
    $display("Something failed");
    $fatal(1);
  end

  // outputs are registered, so mid-cycle they are settled
  always @(negedge clk)
  begin
    if (rst)
    begin
      assert (!arvalid) else stop_on_mismatch("arvalid_o", 32'(arvalid), 32'h0);
      assert (!fetch_valid) else stop_on_mismatch("fetch_valid_o", 32'(fetch_valid), 32'h0);
    end
    else
    begin
      if (arvalid)
      begin
        assert (araddr == (exp_pc >> `L1I_OFS_W) << `L1I_OFS_W)
          else stop_on_mismatch("araddr_o", araddr, (exp_pc >> `L1I_OFS_W) << `L1I_OFS_W);
        assert (!refill_seen) else stop_with("two refills were requested for one fetch");
        assert (!is_cached(araddr)) else stop_with("refill requested for a line that should hit");
        if (ever_filled[index_of(araddr)])
        begin
          refetches++;
        end
        refill_seen = 1'b1;
      end
      if (fetch_valid)
      begin
        assert (!prev_fetch_valid) else stop_with("fetch_valid_o stayed high for two cycles");
        assert (fetch_pc == exp_pc) else stop_on_mismatch("fetch_pc_o", fetch_pc, exp_pc);
        assert (fetch_inst == prog[slot_of(fetch_pc)])
          else stop_on_mismatch("fetch_inst_o", fetch_inst, prog[slot_of(fetch_pc)]);
        assert (refill_seen || is_cached(fetch_pc))
          else stop_with("a fetch of an uncached line completed without a refill");
        if (!refill_seen && fetch_pc >= LOOP_PC)
        begin
          loop_hits++;
        end
        line_valid[index_of(fetch_pc)] = 1'b1;
        line_tag[index_of(fetch_pc)] = tag_of(fetch_pc);
        ever_filled[index_of(fetch_pc)] = 1'b1;
        // FENCE.I is still delivered, then every line is gone
        if (fetch_inst == `FENCE_I_INST)
        begin
          for (int k = 0; k < `L1I_LINES; k++)
          begin
            line_valid[k] = 1'b0;
          end
        end
        exp_pc = succ[slot_of(fetch_pc)];
        refill_seen = 1'b0;
        fetch_count++;
      end
      prev_fetch_valid = fetch_valid;
    end
  end

endmodule

`default_nettype wire

// ==== sim/imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module imem_model #(
  parameter int MAX_GAP = 4
) (
  input  wire                   clk,
  input  wire fetch_pkg::addr_t araddr_i,
  input  wire                   arvalid_i,
  output fetch_pkg::inst_t      rdata_o,
  output logic                  rvalid_o
);
  import fetch_pkg::*;

  localparam int MEM_WORDS = 16;

  inst_t  mem [MEM_WORDS];
  integer seed = 32'had70_4185;

  function automatic logic [3:0] slot_of(input addr_t a);
    addr_t ofs;
    ofs = a - `RESET_PC;
    return ofs[5:2];
  endfunction

  // filler words are OP-IMM, so a stray fetch never jumps or flushes
  initial
  begin
    addr_t a;
    for (int k = 0; k < MEM_WORDS; k++)
    begin
      a = `RESET_PC + addr_t'(4 * k);
      mem[k] = {a[24:0] ^ a[31:7], 7'b001_0011};
    end
  end

  // one line read, two beats, each after a random gap
  initial
  begin
    addr_t base;
    int    gap;
    rvalid_o = 1'b0;
    rdata_o = '0;
    forever
    begin
      @(negedge clk);
      if (arvalid_i)
      begin
        base = araddr_i;
        for (int beat = 0; beat < 2; beat++)
        begin
          gap = int'($unsigned($random(seed)) % MAX_GAP);
          repeat (gap + 1) @(negedge clk);
          rvalid_o = 1'b1;
          rdata_o = mem[slot_of(base + addr_t'(4 * beat))];
          @(negedge clk);
          rvalid_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [`FETCH_ADDR_W-1:0] inst_t;
  typedef logic [`L1I_IDX_W-1:0] l1i_idx_t;

  // address bits above index and byte offset
  typedef logic [`FETCH_ADDR_W-`L1I_IDX_W-`L1I_OFS_W-1:0] l1i_tag_t;

  typedef enum logic [1:0] {
    s_lookup,
    s_refill0,
    s_refill1,
    s_respond
  } l1i_state_e;

endpackage

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_unit (
  input  wire              clk,
  input  wire              rst,
  output fetch_pkg::addr_t araddr_o,
  output logic             arvalid_o,
  input  wire fetch_pkg::inst_t rdata_i,
  input  wire              rvalid_i,
  output logic             fetch_valid_o,
  output fetch_pkg::addr_t fetch_pc_o,
  output fetch_pkg::inst_t fetch_inst_o
);
  import fetch_pkg::*;

  // pc_gen to cache
  logic  req_valid;
  addr_t req_pc;

  // cache to predecode
  logic  resp_valid;
  addr_t resp_pc;
  inst_t resp_inst;

  // predecode back to pc_gen and cache
  logic  done_valid;
  logic  redirect_valid;
  addr_t redirect_pc;
  logic  flush;

  pc_gen pc_gen_i (
    .clk              (clk),
    .rst              (rst),
    .done_valid_i     (done_valid),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .req_valid_o      (req_valid),
    .req_pc_o         (req_pc)
  );

  l1i_cache l1i_cache_i (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid),
    .req_pc_i     (req_pc),
    .flush_i      (flush),
    .resp_valid_o (resp_valid),
    .resp_pc_o    (resp_pc),
    .resp_inst_o  (resp_inst),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i)
  );

  predecode predecode_i (
    .clk              (clk),
    .rst              (rst),
    .resp_valid_i     (resp_valid),
    .resp_pc_i        (resp_pc),
    .resp_inst_i      (resp_inst),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_inst_o     (fetch_inst_o),
    .done_valid_o     (done_valid),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .flush_o          (flush)
  );

endmodule

`default_nettype wire

// ==== source/l1i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module l1i_cache (
  input  wire              clk,
  input  wire              rst,
  input  wire              req_valid_i,
  input  wire fetch_pkg::addr_t req_pc_i,
  input  wire              flush_i,
  output logic             resp_valid_o,
  output fetch_pkg::addr_t resp_pc_o,
  output fetch_pkg::inst_t resp_inst_o,
  output fetch_pkg::addr_t araddr_o,
  output logic             arvalid_o,
  input  wire fetch_pkg::inst_t rdata_i,
  input  wire              rvalid_i
);
  import fetch_pkg::*;

  inst_t    data_q [`L1I_LINES][2];
  l1i_tag_t tag_q [`L1I_LINES];
  logic [`L1I_LINES-1:0] valid_q;

  l1i_state_e state_q;
  addr_t      pc_q;
  logic       hit_q;
  logic       arvalid_q;

  l1i_idx_t req_idx;
  l1i_tag_t req_tag;
  l1i_idx_t cur_idx;
  l1i_tag_t cur_tag;
  logic     cur_wsel;
  logic     req_hit;

  // incoming request, used for the hit check
  assign req_idx = req_pc_i[`L1I_IDX_W+`L1I_OFS_W-1:`L1I_OFS_W];
  assign req_tag = req_pc_i[`FETCH_ADDR_W-1:`L1I_IDX_W+`L1I_OFS_W];

  // latched request, used for refill and response
  assign cur_idx = pc_q[`L1I_IDX_W+`L1I_OFS_W-1:`L1I_OFS_W];
  assign cur_tag = pc_q[`FETCH_ADDR_W-1:`L1I_IDX_W+`L1I_OFS_W];
  assign cur_wsel = pc_q[`L1I_OFS_W-1];

  assign req_hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  // line base of the pending miss
  assign araddr_o = {pc_q[`FETCH_ADDR_W-1:`L1I_OFS_W], {`L1I_OFS_W{1'b0}}};
  assign arvalid_o = arvalid_q;

  assign resp_valid_o = hit_q || (state_q == s_respond);
  assign resp_pc_o = pc_q;
  assign resp_inst_o = data_q[cur_idx][cur_wsel];

  always_ff @(posedge clk)
  begin
    if (req_valid_i)
    begin
      pc_q <= req_pc_i;
    end
  end

  // beat 0 lands in word 0, beat 1 in word 1 along with the tag
  always_ff @(posedge clk)
  begin
    if (rvalid_i && (state_q == s_refill0))
    begin
      data_q[cur_idx][0] <= rdata_i;
    end
    if (rvalid_i && (state_q == s_refill1))
    begin
      data_q[cur_idx][1] <= rdata_i;
      tag_q[cur_idx] <= cur_tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= s_lookup;
      valid_q <= '0;
      hit_q <= 1'b0;
      arvalid_q <= 1'b0;
    end
    else
    begin
      hit_q <= 1'b0;
      arvalid_q <= 1'b0;
      case (state_q)
        s_lookup:
        begin
          if (req_valid_i)
          begin
            if (req_hit)
            begin
              hit_q <= 1'b1;
            end
            else
            begin
              arvalid_q <= 1'b1;
              state_q <= s_refill0;
            end
          end
        end
        s_refill0:
        begin
          if (rvalid_i)
          begin
            state_q <= s_refill1;
          end
        end
        s_refill1:
        begin
          if (rvalid_i)
          begin
            valid_q[cur_idx] <= 1'b1;
            state_q <= s_respond;
          end
        end
        s_respond:
        begin
          state_q <= s_lookup;
        end
        default:
        begin
          state_q <= s_lookup;
        end
      endcase
      // FENCE.I drops every line
      if (flush_i)
      begin
        valid_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_gen (
  input  wire              clk,
  input  wire              rst,
  input  wire              done_valid_i,
  input  wire              redirect_valid_i,
  input  wire fetch_pkg::addr_t redirect_pc_i,
  output logic             req_valid_o,
  output fetch_pkg::addr_t req_pc_o
);
  import fetch_pkg::*;

  addr_t pc_q;
  addr_t pc_next;
  logic  req_q;
  logic  busy_q;
  logic  rst_q;
  logic  launch;
  logic  retire;

  // one-cycle pulse right after reset is released
  assign launch = rst_q && !rst;
  assign retire = done_valid_i && busy_q;
  assign pc_next = redirect_valid_i ? redirect_pc_i : pc_q + addr_t'(4);

  assign req_valid_o = launch || req_q;
  assign req_pc_o = pc_q;

  always_ff @(posedge clk)
  begin
    rst_q <= rst;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= `RESET_PC;
      req_q <= 1'b0;
      busy_q <= 1'b0;
    end
    else
    begin
      // next request goes out the cycle after the previous one retires
      req_q <= retire;
      if (retire)
      begin
        pc_q <= pc_next;
      end
      if (req_valid_o)
      begin
        busy_q <= 1'b1;
      end
      else if (retire)
      begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module predecode (
  input  wire              clk,
  input  wire              rst,
  input  wire              resp_valid_i,
  input  wire fetch_pkg::addr_t resp_pc_i,
  input  wire fetch_pkg::inst_t resp_inst_i,
  output logic             fetch_valid_o,
  output fetch_pkg::addr_t fetch_pc_o,
  output fetch_pkg::inst_t fetch_inst_o,
  output logic             done_valid_o,
  output logic             redirect_valid_o,
  output fetch_pkg::addr_t redirect_pc_o,
  output logic             flush_o
);
  import fetch_pkg::*;

  logic  valid_q;
  addr_t pc_q;
  inst_t inst_q;
  addr_t j_imm;
  logic  is_jal;
  logic  is_fence_i;

  // J-type immediate, imm[20|10:1|11|19:12], sign extended
  assign j_imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                  inst_q[30:21], 1'b0};

  assign is_jal = (inst_q[6:0] == `OPC_JAL);
  assign is_fence_i = (inst_q == `FENCE_I_INST);

  assign fetch_valid_o = valid_q;
  assign fetch_pc_o = pc_q;
  assign fetch_inst_o = inst_q;
  assign done_valid_o = valid_q;

  assign redirect_valid_o = valid_q && is_jal;
  assign redirect_pc_o = pc_q + j_imm;
  assign flush_o = valid_q && is_fence_i;

  always_ff @(posedge clk)
  begin
    if (resp_valid_i)
    begin
      pc_q <= resp_pc_i;
      inst_q <= resp_inst_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= resp_valid_i;
    end
  end

endmodule

`default_nettype wire
